// File: Makefile
# Verilator flow for the AXI4 to AXI4-Lite converter
# Any variable can be overridden on the command line, e.g. make TOP=...

VERILATOR ?= verilator
TOP       ?= tb_axi_to_axi_lite
RTL_TOP   ?= axi_to_axi_lite
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# The testbench ends every failure with $fatal, so the exit status carries the result
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/axi_lite_testdata.hex
// op id user addr len wdata strb resp rdata, one vector per line, all hex
// op 1 write, 2 read, 3 posted write, 4 posted read; posted ops do not wait
// Single-beat write and read back, full and partial strobes
1 11 21 00000010 00 deadbeef f 0 00000000
2 12 22 00000010 00 00000000 0 0 deadbeef
1 13 23 00000014 00 11223344 5 0 00000000
2 14 24 00000014 00 00000000 0 0 c0220544
2 15 25 0000002c 00 00000000 0 0 c0de0b0b
// Slave error region, bit 12 of the address
1 21 31 00001008 00 12345678 f 2 00000000
2 22 32 00001008 00 00000000 0 2 00000000
2 23 33 00000008 00 00000000 0 0 c0de0202
// Write burst rejected locally, memory stays as it was
1 31 41 00000020 03 55aa55aa f 2 00000000
2 32 42 00000020 00 00000000 0 0 c0de0808
// Read burst rejected locally with zero data
2 41 51 00000024 02 00000000 0 2 00000000
// Back to back writes, B order must follow request order
3 51 61 00000030 00 a0a0a0a0 f 0 00000000
3 52 62 00000034 00 b1b1b1b1 f 0 00000000
3 53 63 00000038 01 e4e4e4e4 f 2 00000000
3 54 64 0000103c 00 f5f5f5f5 f 2 00000000
3 55 65 0000003c 00 c2c2c2c2 3 0 00000000
3 56 66 00000000 00 d3d3d3d3 c 0 00000000
// Reads of the posted writes, with a burst mixed into the stream
2 5a 6a 00000038 00 00000000 0 0 c0de0e0e
4 57 67 00000030 00 00000000 0 0 a0a0a0a0
4 5b 6b 00000030 01 00000000 0 2 00000000
4 58 68 0000003c 00 00000000 0 0 c0dec2c2
2 59 69 00000000 00 00000000 0 0 d3d30000

// File: dv/tb_axi_to_axi_lite.sv
/*
 * Testbench for the AXI4 to AXI4-Lite converter
 * An AXI master replays vectors from a hex file, a Lite slave models a
 * 16-word register memory, and every response is checked in request order
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_to_axi_lite;

  localparam int NUM_VEC = 22;
  localparam int VEC_W   = 9;
  localparam int TIMEOUT = 200 * NUM_VEC;
  // Posted operations do not wait for their own response
  localparam logic [31:0] OP_WR        = 32'd1;
  localparam logic [31:0] OP_RD        = 32'd2;
  localparam logic [31:0] OP_WR_POSTED = 32'd3;
  localparam logic [31:0] OP_RD_POSTED = 32'd4;

  typedef struct packed {
    logic [7:0] id;
    logic [7:0] user;
    logic [1:0] resp;
  } b_exp_t;

  typedef struct packed {
    logic [7:0]  id;
    logic [7:0]  user;
    logic [7:0]  len;
    logic [1:0]  resp;
    logic [31:0] data;
  } r_exp_t;

  logic        clk, arst_n;
  logic [7:0]  aw_id, aw_user, aw_len, ar_id, ar_user, ar_len;
  logic [7:0]  b_id, b_user, r_id, r_user;
  logic [31:0] aw_addr, ar_addr, w_data, r_data;
  logic [2:0]  aw_prot, ar_prot, lite_aw_prot, lite_ar_prot;
  logic [3:0]  w_strb, lite_w_strb;
  logic [1:0]  b_resp, r_resp, lite_b_resp, lite_r_resp;
  logic        aw_valid, aw_ready, w_last, w_valid, w_ready, b_valid, b_ready;
  logic        ar_valid, ar_ready, r_last, r_valid, r_ready;
  logic [31:0] lite_aw_addr, lite_w_data, lite_ar_addr, lite_r_data;
  logic        lite_aw_valid, lite_aw_ready, lite_w_valid, lite_w_ready;
  logic        lite_b_valid, lite_b_ready, lite_ar_valid, lite_ar_ready;
  logic        lite_r_valid, lite_r_ready;

  logic [31:0] vec [NUM_VEC*VEC_W];
  logic [31:0] op;
  b_exp_t      exp_b_q[$];
  r_exp_t      exp_r_q[$];
  b_exp_t      b_head;
  r_exp_t      r_head;
  int          r_beat = 0;
  int          cycle_cnt = 0;

  // Lite slave model state
  logic [31:0] slv_mem [16];
  logic [1:0]  slv_b_q[$];
  logic [33:0] slv_r_q[$];
  logic [31:0] slv_aw_addr;
  logic        slv_have_aw;

  axi_to_axi_lite #(
    .ADDR_W         (32),
    .DATA_W         (32),
    .NUM_PENDING_WR (2),
    .NUM_PENDING_RD (2)
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic wait_for_responses;
    while (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic issue_write(input int base);
    b_exp_t e;
    e.id   = vec[base+1][7:0];
    e.user = vec[base+2][7:0];
    e.resp = vec[base+7][1:0];
    exp_b_q.push_back(e);
    aw_id    = e.id;
    aw_user  = e.user;
    aw_addr  = vec[base+3];
    aw_len   = vec[base+4][7:0];
    // Protection bits follow the ID so they differ between requests
    aw_prot  = e.id[2:0];
    aw_valid = 1'b1;
    @(posedge clk);
    while (!aw_ready) @(posedge clk);
    @(negedge clk);
    aw_valid = 1'b0;
    // Burst beats differ per beat so a stray write would change memory
    for (int beat = 0; beat <= int'(aw_len); beat++) begin
      w_data  = vec[base+5] ^ 32'(beat);
      w_strb  = vec[base+6][3:0];
      w_last  = (beat == int'(aw_len));
      w_valid = 1'b1;
      @(posedge clk);
      while (!w_ready) @(posedge clk);
      @(negedge clk);
    end
    w_valid = 1'b0;
    w_last  = 1'b0;
  endtask

  task automatic issue_read(input int base);
    r_exp_t e;
    e.id   = vec[base+1][7:0];
    e.user = vec[base+2][7:0];
    e.len  = vec[base+4][7:0];
    e.resp = vec[base+7][1:0];
    e.data = vec[base+8];
    exp_r_q.push_back(e);
    ar_id    = e.id;
    ar_user  = e.user;
    ar_addr  = vec[base+3];
    ar_len   = e.len;
    ar_prot  = e.id[2:0];
    ar_valid = 1'b1;
    @(posedge clk);
    while (!ar_ready) @(posedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  // The master replays the vectors in file order
  initial begin
    arst_n   = 1'b0;
    aw_id    = '0;
    aw_addr  = '0;
    aw_len   = '0;
    aw_prot  = 3'b010;
    aw_user  = '0;
    aw_valid = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_last   = 1'b0;
    w_valid  = 1'b0;
    ar_id    = '0;
    ar_addr  = '0;
    ar_len   = '0;
    ar_prot  = 3'b010;
    ar_user  = '0;
    ar_valid = 1'b0;
    $readmemh("dv/axi_lite_testdata.hex", vec);
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (int v = 0; v < NUM_VEC; v++) begin
      op = vec[v*VEC_W];
      // A blocking operation starts only after all earlier responses
      if (op == OP_WR || op == OP_RD) begin
        wait_for_responses();
      end
      case (op)
        OP_WR, OP_WR_POSTED: issue_write(v * VEC_W);
        OP_RD, OP_RD_POSTED: issue_read(v * VEC_W);
        default: stop_with_failure($sformatf("vector %0d has an unknown operation code", v));
      endcase
      if (op == OP_WR || op == OP_RD) begin
        wait_for_responses();
      end
    end
    wait_for_responses();
    $display("*** TEST PASSED ***");
    $finish;
  end

  // Random ready on both sides, and the Lite slave's response outputs
  initial begin
    logic [31:0] rng;
    rng           = 32'd44;
    b_ready       = 1'b0;
    r_ready       = 1'b0;
    lite_aw_ready = 1'b0;
    lite_w_ready  = 1'b0;
    lite_ar_ready = 1'b0;
    lite_b_valid  = 1'b0;
    lite_b_resp   = '0;
    lite_r_valid  = 1'b0;
    lite_r_resp   = '0;
    lite_r_data   = '0;
    forever begin
      @(negedge clk);
      rng           = xorshift32(rng);
      b_ready       = |rng[1:0];
      r_ready       = |rng[3:2];
      // The slave takes one address at a time and its data after it
      lite_aw_ready = !slv_have_aw && (|rng[5:4]);
      lite_w_ready  = slv_have_aw && (|rng[7:6]);
      lite_ar_ready = |rng[9:8];
      lite_b_valid  = (slv_b_q.size() != 0);
      if (lite_b_valid) begin
        lite_b_resp = slv_b_q[0];
      end
      lite_r_valid = (slv_r_q.size() != 0);
      if (lite_r_valid) begin
        {lite_r_resp, lite_r_data} = slv_r_q[0];
      end
    end
  end

  // The Lite slave captures transfers on the rising edge
  initial begin
    slv_have_aw = 1'b0;
    slv_aw_addr = '0;
    // Each word starts with a value that depends on its whole index
    for (int i = 0; i < 16; i++) begin
      slv_mem[i] = 32'hc0de_0000 | (32'(i) * 32'h0000_0101);
    end
    forever begin
      @(posedge clk);
      if (lite_b_valid && lite_b_ready) void'(slv_b_q.pop_front());
      if (lite_r_valid && lite_r_ready) void'(slv_r_q.pop_front());
      if (lite_aw_valid && lite_aw_ready) begin
        // A forwarded address carries the request's address and protection
        check_val("lite_aw_addr", lite_aw_addr, aw_addr);
        check_val("lite_aw_prot", 32'(lite_aw_prot), 32'(aw_prot));
        slv_have_aw = 1'b1;
        slv_aw_addr = lite_aw_addr;
      end
      if (lite_w_valid && lite_w_ready) begin
        slv_have_aw = 1'b0;
        if (slv_aw_addr[12]) begin
          slv_b_q.push_back(axi_lite_conv_pkg::RESP_SLVERR);
        end else begin
          for (int b = 0; b < 4; b++) begin
            if (lite_w_strb[b]) slv_mem[slv_aw_addr[5:2]][8*b +: 8] = lite_w_data[8*b +: 8];
          end
          slv_b_q.push_back(axi_lite_conv_pkg::RESP_OKAY);
        end
      end
      if (lite_ar_valid && lite_ar_ready) begin
        check_val("lite_ar_addr", lite_ar_addr, ar_addr);
        check_val("lite_ar_prot", 32'(lite_ar_prot), 32'(ar_prot));
        if (lite_ar_addr[12]) begin
          slv_r_q.push_back({axi_lite_conv_pkg::RESP_SLVERR, 32'h0});
        end else begin
          slv_r_q.push_back({axi_lite_conv_pkg::RESP_OKAY, slv_mem[lite_ar_addr[5:2]]});
        end
      end
    end
  end

  // Write responses must come back in the order the writes were issued
  always @(posedge clk) begin
    if (arst_n && b_valid && b_ready) begin
      if (exp_b_q.size() == 0) begin
        stop_with_failure("a B response arrived with no write outstanding");
      end else begin
        b_head = exp_b_q.pop_front();
        check_val("b_id", 32'(b_id), 32'(b_head.id));
        check_val("b_user", 32'(b_user), 32'(b_head.user));
        check_val("b_resp", 32'(b_resp), 32'(b_head.resp));
      end
    end
  end

  // Each read returns len plus one beats with last only on the final one
  always @(posedge clk) begin
    if (arst_n && r_valid && r_ready) begin
      if (exp_r_q.size() == 0) begin
        stop_with_failure("an R beat arrived with no read outstanding");
      end else begin
        r_head = exp_r_q[0];
        check_val("r_id", 32'(r_id), 32'(r_head.id));
        check_val("r_user", 32'(r_user), 32'(r_head.user));
        check_val("r_resp", 32'(r_resp), 32'(r_head.resp));
        check_val("r_data", r_data, r_head.data);
        check_val("r_last", 32'(r_last), 32'(r_beat == int'(r_head.len)));
        if (r_last) begin
          void'(exp_r_q.pop_front());
          r_beat = 0;
        end else begin
          r_beat = r_beat + 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT) begin
      stop_with_failure($sformatf("timeout after %0d cycles, responses still missing", TIMEOUT));
    end
  end

endmodule

`default_nettype wire

// File: hw/axi_lite_conv_pkg.sv
/*
 * AXI4 to AXI4-Lite converter package
 * Holds the response codes, the ID and user widths and the records that
 * the write and read paths keep for every transaction in flight
 */
`default_nettype none

package axi_lite_conv_pkg;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Default upstream ID and user widths
  localparam int ID_W   = 8;
  localparam int USER_W = 8;

  typedef logic [7:0] len_t;

  // One outstanding write, reject marks a burst that is answered locally
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [USER_W-1:0] user;
    logic              reject;
  } wr_pend_t;

  // One outstanding read, len tells a reject how many beats to return
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [USER_W-1:0] user;
    len_t              len;
    logic              reject;
  } rd_pend_t;

endpackage

`default_nettype wire

// File: hw/axi_lite_rd_conv.sv
/*
 * AXI4 to AXI4-Lite read path
 * Forwards single-beat reads to the Lite slave and answers bursts with
 * zero-data SLVERR beats counted out from the pending queue head
 */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_rd_conv #(
  parameter int ADDR_W      = 32,
  parameter int DATA_W      = 32,
  parameter int NUM_PENDING = 2
) (
  input  wire                                 clk,
  input  wire                                 arst_n,
  input  logic [axi_lite_conv_pkg::ID_W-1:0]   ar_id,
  input  logic [ADDR_W-1:0]                   ar_addr,
  input  axi_lite_conv_pkg::len_t             ar_len,
  input  logic [2:0]                          ar_prot,
  input  logic [axi_lite_conv_pkg::USER_W-1:0] ar_user,
  input  logic                                ar_valid,
  output logic                                ar_ready,
  output logic [axi_lite_conv_pkg::ID_W-1:0]   r_id,
  output logic [DATA_W-1:0]                   r_data,
  output axi_lite_conv_pkg::resp_t            r_resp,
  output logic                                r_last,
  output logic [axi_lite_conv_pkg::USER_W-1:0] r_user,
  output logic                                r_valid,
  input  logic                                r_ready,
  output logic [ADDR_W-1:0]                   lite_ar_addr,
  output logic [2:0]                          lite_ar_prot,
  output logic                                lite_ar_valid,
  input  logic                                lite_ar_ready,
  input  logic [DATA_W-1:0]                   lite_r_data,
  input  axi_lite_conv_pkg::resp_t            lite_r_resp,
  input  logic                                lite_r_valid,
  output logic                                lite_r_ready
);

  logic                        q_full;
  logic                        q_empty;
  logic                        q_push;
  logic                        q_pop;
  axi_lite_conv_pkg::rd_pend_t q_head;
  axi_lite_conv_pkg::rd_pend_t q_data;
  axi_lite_conv_pkg::len_t     beat_cnt;
  logic                        ar_single;
  logic                        r_fire;

  assign ar_single = (ar_len == '0);

  // Single beats need the slave, bursts only need queue space
  assign lite_ar_addr  = ar_addr;
  assign lite_ar_prot  = ar_prot;
  assign lite_ar_valid = ar_valid && !q_full && ar_single;
  assign ar_ready      = ar_valid && !q_full && (ar_single ? lite_ar_ready : 1'b1);

  assign q_push        = ar_valid && ar_ready;
  assign q_data.id     = ar_id;
  assign q_data.user   = ar_user;
  assign q_data.len    = ar_len;
  assign q_data.reject = !ar_single;

  pending_queue #(
    .entry_t (axi_lite_conv_pkg::rd_pend_t),
    .DEPTH   (NUM_PENDING)
  ) u_queue (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (q_push),
    .push_data (q_data),
    .pop       (q_pop),
    .head      (q_head),
    .empty     (q_empty),
    .full      (q_full)
  );

  // A reject head streams len plus one zero beats, a forwarded read one beat
  assign r_valid      = !q_empty && (q_head.reject || lite_r_valid);
  assign r_id         = q_head.id;
  assign r_user       = q_head.user;
  assign r_data       = q_head.reject ? '0 : lite_r_data;
  assign r_resp       = q_head.reject ? axi_lite_conv_pkg::RESP_SLVERR : lite_r_resp;
  assign r_last       = q_head.reject ? (beat_cnt == q_head.len) : 1'b1;
  assign lite_r_ready = r_ready && !q_empty && !q_head.reject;
  assign r_fire       = r_valid && r_ready;
  assign q_pop        = r_fire && r_last;

  // Counter returns to zero on the final beat, ready for the next head
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_cnt <= '0;
    end else if (r_fire && q_head.reject) begin
      beat_cnt <= r_last ? '0 : beat_cnt + 1'b1;
    end
  end

  // The counter never runs past the length of the burst at the head
  a_rej_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
    (!q_empty && q_head.reject) |-> (beat_cnt <= q_head.len))
    else $error("reject burst counter beyond len");

endmodule

`default_nettype wire

// File: hw/axi_lite_wr_conv.sv
/*
 * AXI4 to AXI4-Lite write path
 * Forwards single-beat writes to the Lite slave and drains bursts with a
 * local SLVERR; B responses come back in order from the pending queue
 */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_wr_conv #(
  parameter int ADDR_W      = 32,
  parameter int DATA_W      = 32,
  parameter int NUM_PENDING = 2
) (
  input  wire                                 clk,
  input  wire                                 arst_n,
  input  logic [axi_lite_conv_pkg::ID_W-1:0]   aw_id,
  input  logic [ADDR_W-1:0]                   aw_addr,
  input  axi_lite_conv_pkg::len_t             aw_len,
  input  logic [2:0]                          aw_prot,
  input  logic [axi_lite_conv_pkg::USER_W-1:0] aw_user,
  input  logic                                aw_valid,
  output logic                                aw_ready,
  input  logic [DATA_W-1:0]                   w_data,
  input  logic [DATA_W/8-1:0]                 w_strb,
  input  logic                                w_last,
  input  logic                                w_valid,
  output logic                                w_ready,
  output logic [axi_lite_conv_pkg::ID_W-1:0]   b_id,
  output axi_lite_conv_pkg::resp_t            b_resp,
  output logic [axi_lite_conv_pkg::USER_W-1:0] b_user,
  output logic                                b_valid,
  input  logic                                b_ready,
  output logic [ADDR_W-1:0]                   lite_aw_addr,
  output logic [2:0]                          lite_aw_prot,
  output logic                                lite_aw_valid,
  input  logic                                lite_aw_ready,
  output logic [DATA_W-1:0]                   lite_w_data,
  output logic [DATA_W/8-1:0]                 lite_w_strb,
  output logic                                lite_w_valid,
  input  logic                                lite_w_ready,
  input  axi_lite_conv_pkg::resp_t            lite_b_resp,
  input  logic                                lite_b_valid,
  output logic                                lite_b_ready
);

  typedef enum logic {ST_ADDR, ST_DATA} state_t;

  state_t                          state;
  logic [axi_lite_conv_pkg::ID_W-1:0]   cur_id;
  logic [axi_lite_conv_pkg::USER_W-1:0] cur_user;
  logic                            cur_reject;
  logic                            q_full;
  logic                            q_empty;
  logic                            q_push;
  logic                            q_pop;
  axi_lite_conv_pkg::wr_pend_t     q_head;
  axi_lite_conv_pkg::wr_pend_t     q_data;
  logic                            aw_single;
  logic                            aw_open;
  logic                            w_fire;

  assign aw_single = (aw_len == '0);
  // A new AW may start only once the previous W beats are done
  assign aw_open   = (state == ST_ADDR) && !q_full;

  // Single beats go straight through, bursts are taken here in one cycle
  assign lite_aw_addr  = aw_addr;
  assign lite_aw_prot  = aw_prot;
  assign lite_aw_valid = aw_valid && aw_open && aw_single;
  assign aw_ready      = aw_valid && aw_open && (aw_single ? lite_aw_ready : 1'b1);

  assign lite_w_data  = w_data;
  assign lite_w_strb  = w_strb;
  assign lite_w_valid = w_valid && (state == ST_DATA) && !cur_reject;
  // Rejected bursts are drained without waiting on the slave
  assign w_ready      = w_valid && (state == ST_DATA) && (cur_reject || lite_w_ready);
  assign w_fire       = w_valid && w_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_ADDR;
      cur_reject <= 1'b0;
    end else if (state == ST_ADDR) begin
      if (aw_valid && aw_ready) begin
        state      <= ST_DATA;
        cur_reject <= !aw_single;
      end
    end else if (w_fire && (w_last || !cur_reject)) begin
      state <= ST_ADDR;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      cur_id   <= aw_id;
      cur_user <= aw_user;
    end
  end

  // The record enters the queue on the last W beat of the write
  assign q_push        = (state == ST_DATA) && w_fire && (w_last || !cur_reject);
  assign q_data.id     = cur_id;
  assign q_data.user   = cur_user;
  assign q_data.reject = cur_reject;

  pending_queue #(
    .entry_t (axi_lite_conv_pkg::wr_pend_t),
    .DEPTH   (NUM_PENDING)
  ) u_queue (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (q_push),
    .push_data (q_data),
    .pop       (q_pop),
    .head      (q_head),
    .empty     (q_empty),
    .full      (q_full)
  );

  // B is built from the head, locally for a reject or from the slave otherwise
  assign b_valid      = !q_empty && (q_head.reject || lite_b_valid);
  assign b_id         = q_head.id;
  assign b_user       = q_head.user;
  assign b_resp       = q_head.reject ? axi_lite_conv_pkg::RESP_SLVERR : lite_b_resp;
  assign lite_b_ready = b_ready && !q_empty && !q_head.reject;
  assign q_pop        = b_valid && b_ready;

  // An offered address stays on lite_aw until the slave takes it
  a_lite_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (lite_aw_valid && !lite_aw_ready) |=> (lite_aw_valid && $stable(lite_aw_addr)))
    else $error("lite_aw_valid dropped or lite_aw_addr changed before the transfer");

  // The slave sees one beat per write, so that beat has to close the burst
  a_fwd_w_last: assert property (@(posedge clk) disable iff (!arst_n)
    (lite_w_valid && lite_w_ready) |-> w_last)
    else $error("forwarded W beat without last");

endmodule

`default_nettype wire

// File: hw/axi_to_axi_lite.sv
/*
 * AXI4 to AXI4-Lite converter
 * Joins the independent write and read paths between an AXI4 master and
 * a Lite register slave of the same address and data width
 */
`timescale 1ns/1ps
`default_nettype none

module axi_to_axi_lite #(
  parameter int ADDR_W         = 32,
  parameter int DATA_W         = 32,
  parameter int NUM_PENDING_WR = 2,
  parameter int NUM_PENDING_RD = 2
) (
  input  wire                                 clk,
  input  wire                                 arst_n,
  input  logic [axi_lite_conv_pkg::ID_W-1:0]   aw_id,
  input  logic [ADDR_W-1:0]                   aw_addr,
  input  axi_lite_conv_pkg::len_t             aw_len,
  input  logic [2:0]                          aw_prot,
  input  logic [axi_lite_conv_pkg::USER_W-1:0] aw_user,
  input  logic                                aw_valid,
  output logic                                aw_ready,
  input  logic [DATA_W-1:0]                   w_data,
  input  logic [DATA_W/8-1:0]                 w_strb,
  input  logic                                w_last,
  input  logic                                w_valid,
  output logic                                w_ready,
  output logic [axi_lite_conv_pkg::ID_W-1:0]   b_id,
  output axi_lite_conv_pkg::resp_t            b_resp,
  output logic [axi_lite_conv_pkg::USER_W-1:0] b_user,
  output logic                                b_valid,
  input  logic                                b_ready,
  input  logic [axi_lite_conv_pkg::ID_W-1:0]   ar_id,
  input  logic [ADDR_W-1:0]                   ar_addr,
  input  axi_lite_conv_pkg::len_t             ar_len,
  input  logic [2:0]                          ar_prot,
  input  logic [axi_lite_conv_pkg::USER_W-1:0] ar_user,
  input  logic                                ar_valid,
  output logic                                ar_ready,
  output logic [axi_lite_conv_pkg::ID_W-1:0]   r_id,
  output logic [DATA_W-1:0]                   r_data,
  output axi_lite_conv_pkg::resp_t            r_resp,
  output logic                                r_last,
  output logic [axi_lite_conv_pkg::USER_W-1:0] r_user,
  output logic                                r_valid,
  input  logic                                r_ready,
  output logic [ADDR_W-1:0]                   lite_aw_addr,
  output logic [2:0]                          lite_aw_prot,
  output logic                                lite_aw_valid,
  input  logic                                lite_aw_ready,
  output logic [DATA_W-1:0]                   lite_w_data,
  output logic [DATA_W/8-1:0]                 lite_w_strb,
  output logic                                lite_w_valid,
  input  logic                                lite_w_ready,
  input  axi_lite_conv_pkg::resp_t            lite_b_resp,
  input  logic                                lite_b_valid,
  output logic                                lite_b_ready,
  output logic [ADDR_W-1:0]                   lite_ar_addr,
  output logic [2:0]                          lite_ar_prot,
  output logic                                lite_ar_valid,
  input  logic                                lite_ar_ready,
  input  logic [DATA_W-1:0]                   lite_r_data,
  input  axi_lite_conv_pkg::resp_t            lite_r_resp,
  input  logic                                lite_r_valid,
  output logic                                lite_r_ready
);

  // Writes own AW, W and B
  axi_lite_wr_conv #(
    .ADDR_W      (ADDR_W),
    .DATA_W      (DATA_W),
    .NUM_PENDING (NUM_PENDING_WR)
  ) u_wr (
    .clk (clk), .arst_n (arst_n),
    .aw_id (aw_id), .aw_addr (aw_addr), .aw_len (aw_len), .aw_prot (aw_prot),
    .aw_user (aw_user), .aw_valid (aw_valid), .aw_ready (aw_ready),
    .w_data (w_data), .w_strb (w_strb), .w_last (w_last),
    .w_valid (w_valid), .w_ready (w_ready),
    .b_id (b_id), .b_resp (b_resp), .b_user (b_user),
    .b_valid (b_valid), .b_ready (b_ready),
    .lite_aw_addr (lite_aw_addr), .lite_aw_prot (lite_aw_prot),
    .lite_aw_valid (lite_aw_valid), .lite_aw_ready (lite_aw_ready),
    .lite_w_data (lite_w_data), .lite_w_strb (lite_w_strb),
    .lite_w_valid (lite_w_valid), .lite_w_ready (lite_w_ready),
    .lite_b_resp (lite_b_resp), .lite_b_valid (lite_b_valid),
    .lite_b_ready (lite_b_ready)
  );

  // Reads own AR and R and run alongside writes
  axi_lite_rd_conv #(
    .ADDR_W      (ADDR_W),
    .DATA_W      (DATA_W),
    .NUM_PENDING (NUM_PENDING_RD)
  ) u_rd (
    .clk (clk), .arst_n (arst_n),
    .ar_id (ar_id), .ar_addr (ar_addr), .ar_len (ar_len), .ar_prot (ar_prot),
    .ar_user (ar_user), .ar_valid (ar_valid), .ar_ready (ar_ready),
    .r_id (r_id), .r_data (r_data), .r_resp (r_resp), .r_last (r_last),
    .r_user (r_user), .r_valid (r_valid), .r_ready (r_ready),
    .lite_ar_addr (lite_ar_addr), .lite_ar_prot (lite_ar_prot),
    .lite_ar_valid (lite_ar_valid), .lite_ar_ready (lite_ar_ready),
    .lite_r_data (lite_r_data), .lite_r_resp (lite_r_resp),
    .lite_r_valid (lite_r_valid), .lite_r_ready (lite_r_ready)
  );

endmodule

`default_nettype wire

// File: hw/pending_queue.sv
/*
 * Pending transaction queue
 * Small in-order FIFO for the records of transactions in flight; the
 * payload type is a parameter so reads and writes share one design
 */
`timescale 1ns/1ps
`default_nettype none

module pending_queue #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 2
) (
  input  wire    clk,
  input  wire    arst_n,
  input  logic   push,
  input  entry_t push_data,
  input  logic   pop,
  output entry_t head,
  output logic   empty,
  output logic   full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t             mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;

  // Storage has no reset, only the pointers decide what is valid
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy only moves when exactly one side is active
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // The paths only accept a request while there is space
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    !(push && full))
    else $error("pending_queue push while full");

  // A response must never be taken without a record behind it
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    !(pop && empty))
    else $error("pending_queue pop while empty");

endmodule

`default_nettype wire

// File: sim.f
hw/axi_lite_conv_pkg.sv
hw/pending_queue.sv
hw/axi_lite_wr_conv.sv
hw/axi_lite_rd_conv.sv
hw/axi_to_axi_lite.sv
dv/tb_axi_to_axi_lite.sv
